/* sim.f */
design/uart_rx_pkg.sv
design/uart_rx_sync.sv
design/uart_rx_datapath.sv
design/uart_rx_control.sv
design/uart_rx_handoff.sv
design/uart_rx_top.sv
sim/uart_rx_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the UART receiver testbench with Verilator.
cd "$(dirname "$0")" \
    && verilator --binary --timing --timescale 1ns/1ps \
        --top-module uart_rx_tb -f sim.f -o uart_rx_sim \
    && ./obj_dir/uart_rx_sim \
    || exit 1
exit 0

/* sim/uart_rx_tb.sv */
module uart_rx_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 150000;      // About 14 frames plus margin.

    logic                   clk;
    logic                   reset_b;
    logic                   rx;
    logic                   ack;
    logic                   req;
    uart_rx_pkg::rx_frame_t frame;

    int                     seed;
    int                     cycle_count;
    logic                   req_seen;
    logic                   ack_seen;
    uart_rx_pkg::rx_frame_t frame_seen;

    uart_rx_top u_dut (
        .clk     (clk),
        .reset_b (reset_b),
        .rx      (rx),
        .frame   (frame),
        .req     (req),
        .ack     (ack)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Failure, watchdog and handshake monitor
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "simulation stopped");
    endtask

    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        abort_run("Timeout: the run did not finish within the cycle limit.");
    end

    // Sampled mid cycle, away from the clock edge.
    always @(negedge clk)
    begin
        if (reset_b)
        begin
            if (req && !req_seen && ack_seen)
            begin
                abort_run("Handshake error: req rose while ack was still high.");
            end
            if (req && req_seen && (frame !== frame_seen))
            begin
                abort_run("Handshake error: frame changed while req was high.");
            end
        end
        req_seen   = req;
        ack_seen   = ack;
        frame_seen = frame;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Drivers, consumer and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_bit(input logic level);
        @(posedge clk);
        #2;
        rx = level;
        repeat (int'(uart_rx_pkg::BIT_TICKS) - 1) @(posedge clk);
    endtask

    // Start bit, data LSB first, then the stop bit.
    task automatic send_byte(input logic [7:0] value, input logic stop_level);
        int i;
        drive_bit(1'b0);
        for (i = 0; i < int'(uart_rx_pkg::DATA_BITS); i++)
        begin
            drive_bit(value[i]);
        end
        drive_bit(stop_level);
    endtask

    task automatic idle_line(input int cycles);
        @(posedge clk);
        #2;
        rx = 1'b1;
        repeat (cycles) @(posedge clk);
    endtask

    task automatic take_frame(output uart_rx_pkg::rx_frame_t got);
        do @(negedge clk); while (!req);
        got = frame;
        @(posedge clk);
        #2;
        ack = 1'b1;
        do @(negedge clk); while (req);
        @(posedge clk);
        #2;
        ack = 1'b0;
    endtask

    function automatic uart_rx_pkg::rx_frame_t build_frame(input logic [7:0] value,
                                                           input logic       frame_error,
                                                           input logic       overrun);
        uart_rx_pkg::rx_frame_t f;
        f.data        = value;
        f.frame_error = frame_error;
        f.overrun     = overrun;
        return f;
    endfunction

    task automatic check_frame(input string                  name,
                               input uart_rx_pkg::rx_frame_t exp,
                               input uart_rx_pkg::rx_frame_t act);
        if (act !== exp)
        begin
            abort_run($sformatf(
                "MISMATCH %s: expected data=%h fe=%b ov=%b, actual data=%h fe=%b ov=%b",
                name, exp.data, exp.frame_error, exp.overrun,
                act.data, act.frame_error, act.overrun));
        end
    endtask

    task automatic check_req(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            abort_run($sformatf("MISMATCH %s: expected req=%b, actual req=%b", name, exp, act));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_idle();
        repeat (3000)
        begin
            @(negedge clk);
            check_req("test_reset_idle", 1'b0, req);
        end
    endtask

    task automatic test_single_byte();
        uart_rx_pkg::rx_frame_t got;
        send_byte(8'hA5, 1'b1);
        take_frame(got);
        check_frame("test_single_byte", build_frame(8'hA5, 1'b0, 1'b0), got);
        idle_line(100);
    endtask

    task automatic test_frame_error();
        uart_rx_pkg::rx_frame_t got;
        send_byte(8'h3C, 1'b0);
        idle_line(int'(uart_rx_pkg::BIT_TICKS));  // Line back to idle.
        take_frame(got);
        check_frame("test_frame_error", build_frame(8'h3C, 1'b1, 1'b0), got);
    endtask

    task automatic test_back_to_back();
        logic [7:0]             values [4];
        uart_rx_pkg::rx_frame_t got;
        int                     rnd;
        int                     i;
        int                     j;
        for (i = 0; i < 4; i++)
        begin
            rnd       = $random(seed);
            values[i] = rnd[7:0];
        end
        fork
            begin
                for (i = 0; i < 4; i++)
                begin
                    send_byte(values[i], 1'b1);
                end
            end
            begin
                for (j = 0; j < 4; j++)
                begin
                    take_frame(got);
                    check_frame($sformatf("test_back_to_back[%0d]", j),
                                build_frame(values[j], 1'b0, 1'b0), got);
                end
            end
        join
        idle_line(100);
    endtask

    task automatic test_overrun();
        uart_rx_pkg::rx_frame_t got;
        send_byte(8'h5A, 1'b1);
        do @(negedge clk); while (!req);
        send_byte(8'hC3, 1'b1);                   // Dropped, ack held low.
        take_frame(got);
        check_frame("test_overrun first", build_frame(8'h5A, 1'b0, 1'b0), got);
        repeat (200)
        begin
            @(negedge clk);
            check_req("test_overrun no second req", 1'b0, req);
        end
        send_byte(8'h96, 1'b1);
        take_frame(got);
        check_frame("test_overrun third", build_frame(8'h96, 1'b0, 1'b1), got);
        idle_line(100);
    endtask

    initial
    begin
        seed       = 58;
        reset_b    = 1'b0;
        rx         = 1'b1;
        ack        = 1'b0;
        req_seen   = 1'b0;
        ack_seen   = 1'b0;
        frame_seen = '0;
        repeat (4) @(posedge clk);
        #2;
        reset_b = 1'b1;

        test_reset_idle();
        test_single_byte();
        test_frame_error();
        test_back_to_back();
        test_overrun();

        $display("All tests passed");
        $finish;
    end

endmodule

/* design/uart_rx_top.sv */
module uart_rx_top (
    input  logic                   clk,
    input  logic                   reset_b,
    input  logic                   rx,
    output uart_rx_pkg::rx_frame_t frame,
    output logic                   req,
    input  logic                   ack
);

    logic                    rx_sync;
    logic                    start_edge;
    logic [7:0]              data;
    uart_rx_pkg::rx_ctrl_t   ctrl;
    uart_rx_pkg::rx_status_t status;
    uart_rx_pkg::rx_result_t result;

    uart_rx_sync u_sync (
        .clk        (clk),
        .reset_b    (reset_b),
        .rx         (rx),
        .rx_sync    (rx_sync),
        .start_edge (start_edge)
    );

    uart_rx_datapath u_datapath (
        .clk     (clk),
        .reset_b (reset_b),
        .rx_sync (rx_sync),
        .ctrl    (ctrl),
        .status  (status),
        .data    (data)
    );

    uart_rx_control u_control (
        .clk        (clk),
        .reset_b    (reset_b),
        .start_edge (start_edge),
        .rx_sync    (rx_sync),
        .status     (status),
        .ctrl       (ctrl),
        .result     (result)
    );

    uart_rx_handoff u_handoff (
        .clk     (clk),
        .reset_b (reset_b),
        .data    (data),
        .result  (result),
        .frame   (frame),
        .req     (req),
        .ack     (ack)
    );

endmodule

/* design/uart_rx_handoff.sv */
module uart_rx_handoff (
    input  logic                    clk,
    input  logic                    reset_b,
    input  logic [7:0]              data,
    input  uart_rx_pkg::rx_result_t result,
    output uart_rx_pkg::rx_frame_t  frame,
    output logic                    req,
    input  logic                    ack
);

    logic overrun_pend;
    logic out_free;
    logic accept;

    // Both handshake lines must be low before a new frame goes out.
    assign out_free = ~req & ~ack;
    assign accept   = result.done & out_free;

    ////////////////////////////////////////////////////////////////////////////
    // Handshake and overrun tracking
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
        begin
            req          <= 1'b0;
            overrun_pend <= 1'b0;
        end
        else
        begin
            if (accept)
            begin
                req          <= 1'b1;
                overrun_pend <= 1'b0;     // Reported with this frame.
            end
            else if (req && ack)
            begin
                req <= 1'b0;
            end

            if (result.done && !out_free)
            begin
                overrun_pend <= 1'b1;     // Frame dropped.
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Frame register
    ////////////////////////////////////////////////////////////////////////////

    // Loaded only when req is low, so it stays put while req is high.
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            frame.data        <= data;
            frame.frame_error <= result.stop_error;
            frame.overrun     <= overrun_pend;
        end
    end

endmodule

/* design/uart_rx_control.sv */
module uart_rx_control (
    input  logic                    clk,
    input  logic                    reset_b,
    input  logic                    start_edge,
    input  logic                    rx_sync,
    input  uart_rx_pkg::rx_status_t status,
    output uart_rx_pkg::rx_ctrl_t   ctrl,
    output uart_rx_pkg::rx_result_t result
);

    typedef enum logic [1:0] {
        IDLE,
        FIRST,
        DATA,
        STOP
    } state_t;

    state_t state;
    state_t state_next;

    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Next state and select codes
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        state_next        = state;
        ctrl.baud_op      = uart_rx_pkg::OP_CLEAR;
        ctrl.bit_op       = uart_rx_pkg::OP_CLEAR;
        ctrl.shift        = 1'b0;
        ctrl.first_sample = 1'b0;
        result.done       = 1'b0;
        result.stop_error = 1'b0;

        case (state)
            IDLE:
            begin
                if (start_edge)
                begin
                    state_next = FIRST;
                end
            end

            FIRST:
            begin
                ctrl.first_sample = 1'b1;      // Wait 1.5 bits to mid of bit 0.
                ctrl.bit_op       = uart_rx_pkg::OP_HOLD;
                ctrl.baud_op      = uart_rx_pkg::OP_COUNT;
                if (status.baud_match)
                begin
                    ctrl.baud_op = uart_rx_pkg::OP_CLEAR;
                    ctrl.bit_op  = uart_rx_pkg::OP_COUNT;
                    ctrl.shift   = 1'b1;
                    state_next   = DATA;
                end
            end

            DATA:
            begin
                ctrl.bit_op  = uart_rx_pkg::OP_HOLD;
                ctrl.baud_op = uart_rx_pkg::OP_COUNT;
                if (status.bits_done)
                begin
                    state_next = STOP;         // Baud counter runs on into the stop bit.
                end
                else if (status.baud_match)
                begin
                    ctrl.baud_op = uart_rx_pkg::OP_CLEAR;
                    ctrl.bit_op  = uart_rx_pkg::OP_COUNT;
                    ctrl.shift   = 1'b1;
                end
            end

            STOP:
            begin
                ctrl.bit_op  = uart_rx_pkg::OP_HOLD;
                ctrl.baud_op = uart_rx_pkg::OP_COUNT;
                if (status.baud_match)
                begin
                    result.done       = 1'b1;
                    result.stop_error = ~rx_sync;  // Stop bit must be high.
                    state_next        = IDLE;
                end
            end

            default:
            begin
                state_next = IDLE;
            end
        endcase
    end

endmodule

/* design/uart_rx_datapath.sv */
module uart_rx_datapath (
    input  logic                   clk,
    input  logic                   reset_b,
    input  logic                   rx_sync,
    input  uart_rx_pkg::rx_ctrl_t  ctrl,
    output uart_rx_pkg::rx_status_t status,
    output logic [7:0]             data
);

    logic [uart_rx_pkg::BAUD_W-1:0] baud_cnt;
    logic [uart_rx_pkg::BAUD_W-1:0] baud_limit;
    logic [3:0]                     bit_cnt;

    ////////////////////////////////////////////////////////////////////////////
    // Baud counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
        begin
            baud_cnt <= '0;
        end
        else
        begin
            case (ctrl.baud_op)
                uart_rx_pkg::OP_CLEAR:
                    baud_cnt <= '0;
                uart_rx_pkg::OP_HOLD:
                    baud_cnt <= baud_cnt;
                default:
                    baud_cnt <= baud_cnt + 1'b1;   // OP_COUNT and the spare code.
            endcase
        end
    end

    assign baud_limit = ctrl.first_sample ? uart_rx_pkg::FIRST_SAMPLE_TICKS
                                          : uart_rx_pkg::BIT_TICKS;

    assign status.baud_match = (baud_cnt == baud_limit);

    ////////////////////////////////////////////////////////////////////////////
    // Bit counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
        begin
            bit_cnt <= '0;
        end
        else
        begin
            case (ctrl.bit_op)
                uart_rx_pkg::OP_CLEAR:
                    bit_cnt <= '0;
                uart_rx_pkg::OP_HOLD:
                    bit_cnt <= bit_cnt;
                default:
                    bit_cnt <= bit_cnt + 1'b1;
            endcase
        end
    end

    assign status.bits_done = (bit_cnt == uart_rx_pkg::DATA_BITS);

    ////////////////////////////////////////////////////////////////////////////
    // Shift register
    ////////////////////////////////////////////////////////////////////////////

    // New bit enters at the top, first bit lands in bit 0.
    always_ff @(posedge clk)
    begin
        if (ctrl.shift)
        begin
            data <= {rx_sync, data[7:1]};
        end
    end

endmodule

/* design/uart_rx_sync.sv */
module uart_rx_sync (
    input  logic clk,
    input  logic reset_b,
    input  logic rx,
    output logic rx_sync,
    output logic start_edge
);

    logic rx_meta;
    logic rx_prev;

    // Line idles high, so the flops reset to one.
    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end
        else
        begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;      // Edge detect stage.
        end
    end

    // High for one cycle on the falling edge.
    assign start_edge = rx_prev & ~rx_sync;

endmodule

/* design/uart_rx_pkg.sv */
package uart_rx_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bit timing
    ////////////////////////////////////////////////////////////////////////////

    localparam int BAUD_W = 11;                                  // Baud counter width.

    localparam logic [BAUD_W-1:0] BIT_TICKS          = 11'd868;  // One bit period.
    localparam logic [BAUD_W-1:0] FIRST_SAMPLE_TICKS = 11'd1302; // Edge to mid of bit 0.

    localparam logic [3:0] DATA_BITS = 4'd8;

    ////////////////////////////////////////////////////////////////////////////
    // Counter select codes
    ////////////////////////////////////////////////////////////////////////////

    // Code 2'b11 decodes as a count as well.
    typedef enum logic [1:0] {
        OP_CLEAR = 2'b00,
        OP_HOLD  = 2'b01,
        OP_COUNT = 2'b10
    } counter_op_t;

    ////////////////////////////////////////////////////////////////////////////
    // Block to block bundles
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        counter_op_t baud_op;
        counter_op_t bit_op;
        logic        shift;        // Load one bit into the shifter.
        logic        first_sample; // Compare against 1.5 bits.
    } rx_ctrl_t;

    typedef struct packed {
        logic baud_match;
        logic bits_done;
    } rx_status_t;

    typedef struct packed {
        logic done;                // Single cycle.
        logic stop_error;
    } rx_result_t;

    typedef struct packed {
        logic [7:0] data;
        logic       frame_error;
        logic       overrun;       // Frames lost before this one.
    } rx_frame_t;

endpackage
